/* filelist.f */
src/rv_regs_pkg.sv
src/bram_dual_re.sv
src/ras_stack.sv
src/rv32im_registers.sv
src/clear_counter.sv
src/regs_ctrl.sv
src/regs_top.sv
bench/tb_regs_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_regs_top -o sim_regs

out=$(./obj_dir/sim_regs)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED"

/* bench/tb_regs_top.sv */
`timescale 1ns/10ps

module tb_regs_top;

  import rv_regs_pkg::*;

  localparam int          XLEN      = 32;
  localparam int          REG_BITS  = 5;
  localparam int          RAS_BITS  = 3;
  localparam int          RAS_DEPTH = 2**RAS_BITS;
  localparam logic [31:0] SEED      = 32'h7f65dba6;
  // x^32 + x^22 + x^2 + x + 1, right-shifting form
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;
  localparam int          TIMEOUT   = 200;
  localparam int          N_OPS     = 300;

  logic                clk_i;
  logic                rst_i;
  logic                cmd_valid_i;
  regs_op_e            cmd_op_i;
  logic [REG_BITS-1:0] rs1_addr_i;
  logic [REG_BITS-1:0] rs2_addr_i;
  logic [REG_BITS-1:0] rd_addr_i;
  logic [XLEN-1:0]     data_i;
  logic [XLEN-1:0]     pc_i;
  logic                ready_o;
  logic                opnd_valid_o;
  logic [XLEN-1:0]     rs1_o;
  logic [XLEN-1:0]     rs2_o;
  logic                ras_valid_o;
  logic [XLEN-1:0]     ras_o;
  logic                ras_err_o;

  // reference model, x0 never written
  logic [31:0] model_regs [32];
  logic [31:0] model_stack [$];
  logic        model_err;
  // responses still owed by the DUT, oldest first
  logic [31:0] exp_rs1_q [$];
  logic [31:0] exp_rs2_q [$];
  logic [31:0] exp_ras_q [$];
  // cycle in which each response is due
  int          rd_due_q [$];
  int          ras_due_q [$];
  int          cyc;
  logic [31:0] lfsr_q;
  string       test_name;
  int          errors;
  int          checks;

  regs_top #(
    .XLEN    (XLEN),
    .REG_BITS(REG_BITS),
    .RAS_BITS(RAS_BITS)
  ) uut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .rs1_addr_i  (rs1_addr_i),
    .rs2_addr_i  (rs2_addr_i),
    .rd_addr_i   (rd_addr_i),
    .data_i      (data_i),
    .pc_i        (pc_i),
    .ready_o     (ready_o),
    .opnd_valid_o(opnd_valid_o),
    .rs1_o       (rs1_o),
    .rs2_o       (rs2_o),
    .ras_valid_o (ras_valid_o),
    .ras_o       (ras_o),
    .ras_err_o   (ras_err_o)
  );

  // 4 ns period
  always #2 clk_i = ~clk_i;

  // cycle count, bumped after every rising edge
  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? LFSR_TAPS : 32'h0);
  endfunction

  // one lfsr step per bit, msb drawn first
  function automatic logic [31:0] draw(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[ERROR] test %s, %s expected 0x%08h actual 0x%08h", test_name, what, exp, act);
      errors++;
    end
  endtask

  // raw strobe, no model update
  task automatic drive_cmd(input regs_op_e op, input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [4:0] rd, input logic [31:0] data, input logic [31:0] pc);
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_op_i    <= op;
    rs1_addr_i  <= rs1;
    rs2_addr_i  <= rs2;
    rd_addr_i   <= rd;
    data_i      <= data;
    pc_i        <= pc;
  endtask

  // accepted command, model follows in issue order
  task automatic issue(input regs_op_e op, input logic [4:0] rs1, input logic [4:0] rs2,
                       input logic [4:0] rd, input logic [31:0] data, input logic [31:0] pc);
    logic [31:0] link;
    link = pc + 32'd4;
    drive_cmd(op, rs1, rs2, rd, data, pc);
    case (op)
      OP_READ: begin
        exp_rs1_q.push_back(model_regs[rs1]);
        exp_rs2_q.push_back(model_regs[rs2]);
        // taken at the next edge, answered one cycle after that
        rd_due_q.push_back(cyc + 2);
      end
      OP_WRITE: begin
        if (rd != 5'd0) model_regs[rd] = data;
      end
      OP_CALL: begin
        if (rd != 5'd0) model_regs[rd] = link;
        // full stack drops the push
        if (model_stack.size() < RAS_DEPTH) model_stack.push_back(link);
        else model_err = 1'b1;
      end
      default: begin
        ras_due_q.push_back(cyc + 2);
        if (model_stack.size() > 0) begin
          exp_ras_q.push_back(model_stack.pop_back());
        end else begin
          // underflow pops zero
          exp_ras_q.push_back(32'h0);
          model_err = 1'b1;
        end
      end
    endcase
  endtask

  task automatic issue_rand(input regs_op_e op);
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] p;
    r = draw(15);
    d = draw(32);
    p = draw(32);
    issue(op, r[14:10], r[9:5], r[4:0], d, p);
  endtask

  // go idle, wait out pending responses, then compare the sticky error
  task automatic drain();
    int n;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    n = 0;
    while ((exp_rs1_q.size() != 0 || exp_ras_q.size() != 0) && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    assert (n < TIMEOUT) else begin
      $display("test %s timed out waiting for read or return responses", test_name);
      errors++;
    end
    @(negedge clk_i);
    check_val("ras_err_o", {31'b0, model_err}, {31'b0, ras_err_o});
  endtask

  // response checker, sampled mid-cycle
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (opnd_valid_o) begin
        assert (exp_rs1_q.size() != 0) else begin
          $display("test %s got opnd_valid_o with no read outstanding", test_name);
          errors++;
        end
        if (exp_rs1_q.size() != 0) begin
          check_val("opnd_valid_o cycle", rd_due_q.pop_front(), cyc);
          check_val("rs1_o", exp_rs1_q.pop_front(), rs1_o);
          check_val("rs2_o", exp_rs2_q.pop_front(), rs2_o);
        end
      end
      if (ras_valid_o) begin
        assert (exp_ras_q.size() != 0) else begin
          $display("test %s got ras_valid_o with no return outstanding", test_name);
          errors++;
        end
        if (exp_ras_q.size() != 0) begin
          check_val("ras_valid_o cycle", ras_due_q.pop_front(), cyc);
          check_val("ras_o", exp_ras_q.pop_front(), ras_o);
        end
      end
    end
  end

  initial begin : stim
    logic [31:0] r;
    logic [4:0]  a;
    logic [4:0]  call_rd [4];
    int          n;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_op_i    = OP_READ;
    rs1_addr_i  = '0;
    rs2_addr_i  = '0;
    rd_addr_i   = '0;
    data_i      = '0;
    pc_i        = '0;
    lfsr_q      = SEED;
    model_err   = 1'b0;
    cyc         = 0;
    errors      = 0;
    checks      = 0;
    for (int i = 0; i < 32; i++) model_regs[i] = 32'h0;

    // reset held 16 cycles, outputs quiet inside it
    test_name = "reset";
    repeat (15) @(posedge clk_i);
    @(negedge clk_i);
    check_val("ready_o", 32'h0, {31'b0, ready_o});
    check_val("opnd_valid_o", 32'h0, {31'b0, opnd_valid_o});
    check_val("ras_valid_o", 32'h0, {31'b0, ras_valid_o});
    check_val("ras_err_o", 32'h0, {31'b0, ras_err_o});
    @(posedge clk_i);
    rst_i <= 1'b0;

    // strobes during the sweep, half its length, must all be dropped
    test_name = "sweep strobes";
    for (int i = 0; i < 16; i++) begin
      r = draw(32);
      drive_cmd(regs_op_e'(r[1:0]), r[6:2], r[11:7], r[16:12], draw(32), draw(32));
    end
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!ready_o && n < TIMEOUT);
    assert (ready_o) else begin
      $display("ready_o did not rise after the reset sweep");
      errors++;
    end

    // every pair reads zero after the sweep
    test_name = "zero after sweep";
    for (int i = 0; i < 32; i++) begin
      a = i[4:0];
      issue(OP_READ, a, 5'd31 - a, 5'd0, 32'h0, 32'h0);
    end
    drain();

    // random writes and back-to-back reads, x0 included
    test_name = "write read";
    for (int i = 0; i < N_OPS; i++) begin
      r = draw(1);
      issue_rand(r[0] ? OP_WRITE : OP_READ);
    end
    issue(OP_WRITE, 5'd0, 5'd0, 5'd0, 32'hdeadbeef, 32'h0);
    issue(OP_READ, 5'd0, 5'd0, 5'd0, 32'h0, 32'h0);
    drain();

    // nested calls, link reads, returns in lifo order
    test_name = "call return";
    for (int i = 0; i < 4; i++) begin
      r = draw(5);
      call_rd[i] = r[4:0];
      issue(OP_CALL, 5'd0, 5'd0, r[4:0], 32'h0, draw(32));
    end
    for (int i = 0; i < 4; i++) issue(OP_READ, call_rd[i], call_rd[3-i], 5'd0, 32'h0, 32'h0);
    for (int i = 0; i < 4; i++) issue_rand(OP_RET);
    drain();

    // two pushes past full, then one pop past empty
    test_name = "ras overflow";
    for (int i = 0; i < RAS_DEPTH + 2; i++) issue_rand(OP_CALL);
    for (int i = 0; i < RAS_DEPTH + 1; i++) issue_rand(OP_RET);
    drain();

    // all opcodes mixed, error flag must stay set
    test_name = "random mix";
    for (int i = 0; i < N_OPS; i++) begin
      r = draw(2);
      issue_rand(regs_op_e'(r[1:0]));
    end
    drain();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* src/regs_top.sv */
`timescale 1ns/10ps

module regs_top #(
  parameter int XLEN     = rv_regs_pkg::XLEN_DEF,
  parameter int REG_BITS = rv_regs_pkg::REG_BITS_DEF,
  parameter int RAS_BITS = rv_regs_pkg::RAS_BITS_DEF
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cmd_valid_i,
  input  rv_regs_pkg::regs_op_e cmd_op_i,
  input  logic [REG_BITS-1:0]   rs1_addr_i,
  input  logic [REG_BITS-1:0]   rs2_addr_i,
  input  logic [REG_BITS-1:0]   rd_addr_i,
  input  logic [XLEN-1:0]       data_i,
  input  logic [XLEN-1:0]       pc_i,
  output logic                  ready_o,
  output logic                  opnd_valid_o,
  output logic [XLEN-1:0]       rs1_o,
  output logic [XLEN-1:0]       rs2_o,
  output logic                  ras_valid_o,
  output logic [XLEN-1:0]       ras_o,
  output logic                  ras_err_o
);

  // sweep handshake
  logic                clr_en;
  logic                clearing;
  logic [REG_BITS-1:0] clr_addr;
  logic                clr_last;
  // register file strobes
  logic                wr_en;
  logic [REG_BITS-1:0] wr_addr;
  logic [XLEN-1:0]     wr_data;
  logic                rd_en;
  logic                push;
  logic                pop;

  regs_ctrl #(
    .XLEN    (XLEN),
    .REG_BITS(REG_BITS)
  ) u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .rd_addr_i   (rd_addr_i),
    .data_i      (data_i),
    .pc_i        (pc_i),
    .clr_addr_i  (clr_addr),
    .clr_last_i  (clr_last),
    .clr_en_o    (clr_en),
    .clearing_o  (clearing),
    .ready_o     (ready_o),
    .wr_en_o     (wr_en),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .rd_en_o     (rd_en),
    .push_o      (push),
    .pop_o       (pop),
    .opnd_valid_o(opnd_valid_o),
    .ras_valid_o (ras_valid_o)
  );

  // zero sweep address source
  clear_counter #(
    .REG_BITS(REG_BITS)
  ) u_clr (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .en_i  (clr_en),
    .addr_o(clr_addr),
    .last_o(clr_last)
  );

  // banks plus return stack
  rv32im_registers #(
    .XLEN    (XLEN),
    .REG_BITS(REG_BITS),
    .RAS_BITS(RAS_BITS)
  ) u_regs (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .clearing_i(clearing),
    .write_i   (wr_en),
    .read_i    (rd_en),
    .waddr_i   (wr_addr),
    .data_i    (wr_data),
    .rs1_addr_i(rs1_addr_i),
    .rs2_addr_i(rs2_addr_i),
    .rs1_o     (rs1_o),
    .rs2_o     (rs2_o),
    .push_i    (push),
    .pop_i     (pop),
    .pc_i      (pc_i),
    .ras_o     (ras_o),
    .ras_err_o (ras_err_o)
  );

endmodule

/* src/regs_ctrl.sv */
`timescale 1ns/10ps

module regs_ctrl #(
  parameter int XLEN     = rv_regs_pkg::XLEN_DEF,
  parameter int REG_BITS = rv_regs_pkg::REG_BITS_DEF
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 cmd_valid_i,
  input  rv_regs_pkg::regs_op_e cmd_op_i,
  input  logic [REG_BITS-1:0]  rd_addr_i,
  input  logic [XLEN-1:0]      data_i,
  input  logic [XLEN-1:0]      pc_i,
  input  logic [REG_BITS-1:0]  clr_addr_i,
  input  logic                 clr_last_i,
  output logic                 clr_en_o,
  output logic                 clearing_o,
  output logic                 ready_o,
  output logic                 wr_en_o,
  output logic [REG_BITS-1:0]  wr_addr_o,
  output logic [XLEN-1:0]      wr_data_o,
  output logic                 rd_en_o,
  output logic                 push_o,
  output logic                 pop_o,
  output logic                 opnd_valid_o,
  output logic                 ras_valid_o
);

  import rv_regs_pkg::*;

  regs_state_e state_q;
  logic [XLEN-1:0] link;

  // link value written to rd on a call
  assign link = pc_i + XLEN'(32'd4);

  // sweep until the counter hits the top register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_CLEAR;
    end else if ((state_q == ST_CLEAR) && clr_last_i) begin
      state_q <= ST_RUN;
    end
  end

  assign clearing_o = (state_q == ST_CLEAR);
  // counter only runs during the sweep
  assign clr_en_o   = clearing_o;
  assign ready_o    = (state_q == ST_RUN);

  // command decode and write mux
  always_comb begin
    wr_en_o   = 1'b0;
    wr_addr_o = rd_addr_i;
    wr_data_o = data_i;
    rd_en_o   = 1'b0;
    push_o    = 1'b0;
    pop_o     = 1'b0;
    if (clearing_o) begin
      // zero one register per cycle
      wr_en_o   = 1'b1;
      wr_addr_o = clr_addr_i;
      wr_data_o = '0;
    end else if (cmd_valid_i) begin
      // ready_o is high here, so the strobe is taken
      case (cmd_op_i)
        OP_READ: begin
          rd_en_o = 1'b1;
        end
        OP_WRITE: begin
          wr_en_o = 1'b1;
        end
        OP_CALL: begin
          wr_en_o   = 1'b1;
          wr_data_o = link;
          push_o    = 1'b1;
        end
        OP_RET: begin
          pop_o = 1'b1;
        end
        default: begin
          rd_en_o = 1'b0;
        end
      endcase
    end
  end

  // valid strobes line up with the registered RAM and stack outputs
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      opnd_valid_o <= 1'b0;
      ras_valid_o  <= 1'b0;
    end else begin
      opnd_valid_o <= rd_en_o;
      ras_valid_o  <= pop_o;
    end
  end

  // nothing answers a strobe that arrived during the sweep
  a_quiet_clear: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == ST_CLEAR) |=> !(opnd_valid_o || ras_valid_o))
    else $error("response strobe after a cycle in the sweep");

endmodule

/* src/clear_counter.sv */
`timescale 1ns/10ps

module clear_counter #(
  parameter int REG_BITS = rv_regs_pkg::REG_BITS_DEF
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                en_i,
  output logic [REG_BITS-1:0] addr_o,
  output logic                last_o
);

  // sweep address, one step per enabled cycle
  // wraps back to zero after the last register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      addr_o <= '0;
    end else if (en_i) begin
      addr_o <= addr_o + 1'b1;
    end
  end

  // terminal count, top register
  assign last_o = &addr_o;

endmodule

/* src/rv32im_registers.sv */
`timescale 1ns/10ps

module rv32im_registers #(
  parameter int XLEN     = rv_regs_pkg::XLEN_DEF,
  parameter int REG_BITS = rv_regs_pkg::REG_BITS_DEF,
  parameter int RAS_BITS = rv_regs_pkg::RAS_BITS_DEF
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                clearing_i,
  input  logic                write_i,
  input  logic                read_i,
  input  logic [REG_BITS-1:0] waddr_i,
  input  logic [XLEN-1:0]     data_i,
  input  logic [REG_BITS-1:0] rs1_addr_i,
  input  logic [REG_BITS-1:0] rs2_addr_i,
  output logic [XLEN-1:0]     rs1_o,
  output logic [XLEN-1:0]     rs2_o,
  input  logic                push_i,
  input  logic                pop_i,
  input  logic [XLEN-1:0]     pc_i,
  output logic [XLEN-1:0]     ras_o,
  output logic                ras_err_o
);

  logic            bank_we;
  logic [XLEN-1:0] ret_addr;

  // x0 stays zero, only the sweep may touch it
  assign bank_we  = write_i && (clearing_i || (waddr_i != '0));
  // return address for call
  assign ret_addr = pc_i + XLEN'(32'd4);

  // rs1 bank, shares the write port with rs2
  bram_dual_re #(
    .MEM_BITS(REG_BITS),
    .DATA_W  (XLEN)
  ) u_bank_rs1 (
    .clk_i  (clk_i),
    .write_i(bank_we),
    .read_i (read_i),
    .waddr_i(waddr_i),
    .raddr_i(rs1_addr_i),
    .data_i (data_i),
    .data_o (rs1_o)
  );

  // rs2 bank, identical copy of rs1
  bram_dual_re #(
    .MEM_BITS(REG_BITS),
    .DATA_W  (XLEN)
  ) u_bank_rs2 (
    .clk_i  (clk_i),
    .write_i(bank_we),
    .read_i (read_i),
    .waddr_i(waddr_i),
    .raddr_i(rs2_addr_i),
    .data_i (data_i),
    .data_o (rs2_o)
  );

  // return address stack
  ras_stack #(
    .XLEN    (XLEN),
    .RAS_BITS(RAS_BITS)
  ) u_ras (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .push_i(push_i),
    .pop_i (pop_i),
    .data_i(ret_addr),
    .data_o(ras_o),
    .err_o (ras_err_o)
  );

  // any x0 write that slipped past the sweep shows up on a later read
  a_x0_reads_zero: assert property (@(posedge clk_i) disable iff (rst_i)
    (read_i && !clearing_i && (rs1_addr_i == '0)) |=> (rs1_o == '0))
    else $error("x0 read back nonzero after the sweep");

endmodule

/* src/ras_stack.sv */
`timescale 1ns/10ps

module ras_stack #(
  parameter int XLEN     = rv_regs_pkg::XLEN_DEF,
  parameter int RAS_BITS = rv_regs_pkg::RAS_BITS_DEF
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            push_i,
  input  logic            pop_i,
  input  logic [XLEN-1:0] data_i,
  output logic [XLEN-1:0] data_o,
  output logic            err_o
);

  // capacity as a pointer value, e.g. 4'b1000 for 8 entries
  localparam logic [RAS_BITS:0] CAP = {1'b1, {RAS_BITS{1'b0}}};

  logic [XLEN-1:0]     mem [2**RAS_BITS];
  // depth pointer, one bit wider so full differs from empty
  logic [RAS_BITS:0]   depth_q;
  logic                full;
  logic                empty;
  logic [RAS_BITS-1:0] top_idx;

  assign full  = (depth_q == CAP);
  assign empty = (depth_q == '0);
  // newest entry sits just below the pointer
  // wraps to the last slot when full
  assign top_idx = depth_q[RAS_BITS-1:0] - 1'b1;

  // pointer and sticky error
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      depth_q <= '0;
      err_o   <= 1'b0;
    end else if (push_i) begin
      // overflow drops the push
      if (full) begin
        err_o <= 1'b1;
      end else begin
        depth_q <= depth_q + 1'b1;
      end
    end else if (pop_i) begin
      // underflow leaves the pointer at zero
      if (empty) begin
        err_o <= 1'b1;
      end else begin
        depth_q <= depth_q - 1'b1;
      end
    end
  end

  // entry storage and popped value
  always_ff @(posedge clk_i) begin
    if (push_i && !full) begin
      mem[depth_q[RAS_BITS-1:0]] <= data_i;
    end
    if (pop_i) begin
      // empty pop returns zero
      data_o <= empty ? '0 : mem[top_idx];
    end
  end

  // controller issues one command per cycle
  a_push_pop_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(push_i && pop_i))
    else $error("ras push and pop together");

  a_depth_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    depth_q <= CAP)
    else $error("ras depth past capacity");

endmodule

/* src/bram_dual_re.sv */
`timescale 1ns/10ps

module bram_dual_re #(
  parameter int MEM_BITS = rv_regs_pkg::REG_BITS_DEF,
  parameter int DATA_W   = rv_regs_pkg::XLEN_DEF
) (
  input  logic                clk_i,
  input  logic                write_i,
  input  logic                read_i,
  input  logic [MEM_BITS-1:0] waddr_i,
  input  logic [MEM_BITS-1:0] raddr_i,
  input  logic [DATA_W-1:0]   data_i,
  output logic [DATA_W-1:0]   data_o
);

  // word array, maps onto block RAM
  logic [DATA_W-1:0] mem [2**MEM_BITS];

  // write port
  always_ff @(posedge clk_i) begin
    if (write_i) begin
      mem[waddr_i] <= data_i;
    end
  end

  // read port, output register holds between reads
  // same-address write in the same cycle returns the old word
  always_ff @(posedge clk_i) begin
    if (read_i) begin
      data_o <= mem[raddr_i];
    end
  end

  // an X address would corrupt an unknown word
  a_waddr_known: assert property (@(posedge clk_i) write_i |-> !$isunknown(waddr_i))
    else $error("bram write with unknown address");

endmodule

/* src/rv_regs_pkg.sv */
package rv_regs_pkg;

  // default widths, the top level overrides them
  // data path width
  localparam int XLEN_DEF     = 32;
  // register address, 32 registers
  localparam int REG_BITS_DEF = 5;
  // return stack address, 8 entries
  localparam int RAS_BITS_DEF = 3;

  // command opcodes, one per strobe
  typedef enum logic [1:0] {
    // fetch rs1 and rs2
    OP_READ  = 2'b00,
    // store data into rd
    OP_WRITE = 2'b01,
    // push pc+4 and link into rd
    OP_CALL  = 2'b10,
    // pop the return stack
    OP_RET   = 2'b11
  } regs_op_e;

  // controller state
  typedef enum logic {
    // zero sweep after reset
    ST_CLEAR = 1'b0,
    // taking commands
    ST_RUN   = 1'b1
  } regs_state_e;

endpackage
